//--- src/emmc_link_pkg.sv
// Link constants and types for the eMMC word-level SerDes core
// Both lanes carry one LANE_W word per txclk_div cycle, bit 7 first on the wire

package emmc_link_pkg;

   // Lane geometry
   localparam int LANE_W = 8;                 // Bits per lane word
   localparam int DAT_W  = 4;                 // eMMC data bus width carried in a frame

   // Clock lane training word
   // Bit 7 first gives 1,1,0,0,0,0,1,1 on the wire
   // Every rotation of it is distinct, so only one slip offset can match
   localparam logic [LANE_W-1:0] CLK_PATTERN = 8'hC3;

   // Aligner pacing
   localparam int SLIP_WAIT_DEF = 3;          // Cycles between a slip and the next test

   // Slip offset, one step per bit of the lane word
   typedef logic [2:0] slip_t;                // Range 0 to 7

   // One data lane word
   // Field order matches the bit order on the wire, cmd goes out first
   typedef struct packed {
      logic             cmd;                  // CMD line level
      logic             cmd_oe;               // CMD tristate control
      logic             dat_oe;               // DAT tristate control
      logic [DAT_W-1:0] dat;                  // DAT[3:0] levels
      logic             spare;                // Unused slot, always sent as 0
   } emmc_frame_t;

   // Bus released state
   // Tristate controls high and lines pulled up, as the card sees an idle bus
   localparam emmc_frame_t IDLE_FRAME = '{
      cmd:    1'b1,
      cmd_oe: 1'b1,
      dat_oe: 1'b1,
      dat:    {DAT_W{1'b1}},
      spare:  1'b0
   };

   // Lock time bound for a given wait setting
   // Up to eight slip rounds of wait + 2 cycles, plus the gearbox pipeline
   function automatic int lock_bound(input int slip_wait);
      int bound;
      bound = 8 * (slip_wait + 2) + 4;
      return bound;
   endfunction

endpackage

//--- src/emmc_frame_packer.sv
`timescale 1ns/100ps

// Transmit side word builder
// Packs the eMMC command and data signals into the data lane word and
// keeps the clock lane loaded with the training pattern

module emmc_frame_packer
   import emmc_link_pkg::*;
(
   input  logic              txclk_div,      // Word clock
   input  logic              rst,            // Synchronous, active low
   input  logic              cmd_i,          // CMD level from the host controller
   input  logic              cmd_oe_i,       // CMD tristate control
   input  logic              dat_oe_i,       // DAT tristate control
   input  logic [DAT_W-1:0]  dat_i,          // DAT[3:0] levels
   output emmc_frame_t       tx_dat_word_o,  // Data lane word to the serializer
   output logic [LANE_W-1:0] tx_clk_word_o   // Clock lane word to the serializer
);

   emmc_frame_t       frame_d;               // Frame assembled from this cycle's inputs
   emmc_frame_t       frame_q;               // Registered data lane word
   logic [LANE_W-1:0] clk_word_q;            // Registered clock lane word

   // Field mapping, cmd lands in bit 7 so it is the first bit out
   always_comb begin
      frame_d        = IDLE_FRAME;
      frame_d.cmd    = cmd_i;
      frame_d.cmd_oe = cmd_oe_i;
      frame_d.dat_oe = dat_oe_i;
      frame_d.dat    = dat_i;
      frame_d.spare  = 1'b0;                 // Spare slot is never driven
   end

   // One cycle from input sample to lane word
   always_ff @(posedge txclk_div) begin
      if (!rst) begin
         frame_q    <= IDLE_FRAME;           // Bus looks released while in reset
         clk_word_q <= CLK_PATTERN;          // Forwarded clock runs from the start
      end else begin
         frame_q    <= frame_d;
         clk_word_q <= CLK_PATTERN;          // Fixed pattern, same word every cycle
      end
   end

   // The serializer takes these words as they stand
   assign tx_dat_word_o = frame_q;
   assign tx_clk_word_o = clk_word_q;

endmodule

//--- src/emmc_lane_gearbox.sv
`timescale 1ns/100ps

// Bitslip barrel shifter for one received lane
// The deserializer hands over a word per cycle with unknown bit phase.
// Keeping the previous word lets any 8-bit window across the word
// boundary be picked out, which is what a hardware bitslip does.
//
// Offset k selects the window that starts k bits into the previous word
// and runs on into the current one. Offset 0 passes the previous word.

module emmc_lane_gearbox
   import emmc_link_pkg::*;
#(
   parameter int WORD_W = LANE_W                // Lane word width
)(
   input  logic              txclk_div,         // Word clock
   input  logic              rst,               // Synchronous, active low
   input  logic [WORD_W-1:0] word_i,            // Raw word from the deserializer
   input  slip_t             slip_offset_i,     // Window start, in bits
   output logic [WORD_W-1:0] word_o             // Realigned word
);

   logic [WORD_W-1:0]   hist_q;                 // Word captured on the previous edge
   logic [WORD_W-1:0]   word_q;                 // Registered window
   logic [2*WORD_W-1:0] pair;                   // Previous word followed by current word
   logic [2*WORD_W-1:0] pair_sh;                // Pair moved left by the offset
   logic [WORD_W-1:0]   window;                 // Selected bits

   // Earliest bit on the wire sits at the top of the pair
   assign pair = {hist_q, word_i};

   // Dropping k leading bits brings the window to the top
   assign pair_sh = pair << slip_offset_i;
   assign window  = pair_sh[2*WORD_W-1 -: WORD_W];

   // History and output both advance every edge
   // The offset in effect at the edge decides the window
   always_ff @(posedge txclk_div) begin
      if (!rst) begin
         hist_q <= '1;                          // Idle line level
         word_q <= '1;
      end else begin
         hist_q <= word_i;
         word_q <= window;
      end
   end

   assign word_o = word_q;

endmodule

//--- src/emmc_bitslip_aligner.sv
`timescale 1ns/100ps

// Word alignment controller
// Watches the realigned clock lane and walks the shared slip offset one bit
// at a time until the lane shows the training pattern.
//
// One slip round is check, slip, settle and then wait. Settle covers the
// gearbox output register and counts as the first wait cycle, so a round
// takes SLIP_WAIT + 2 cycles. Once the pattern is seen the offset holds.

module emmc_bitslip_aligner
   import emmc_link_pkg::*;
#(
   parameter int SLIP_WAIT = SLIP_WAIT_DEF      // Cycles from a slip to the next test
)(
   input  logic              txclk_div,         // Word clock
   input  logic              rst,               // Synchronous, active low
   input  logic [LANE_W-1:0] clk_word_i,        // Realigned clock lane word
   output slip_t             slip_offset_o,     // Offset for both gearboxes
   output logic              locked_o           // Clock lane matches the pattern
);

   typedef enum logic [1:0] {
      ST_CHECK  = 2'd0,                         // Compare clock word every cycle
      ST_SLIP   = 2'd1,                         // Step the offset
      ST_SETTLE = 2'd2,                         // Gearbox picks up the new offset
      ST_WAIT   = 2'd3                          // Let the new window flush through
   } state_t;

   localparam int CNT_W = $clog2(SLIP_WAIT + 2);

   state_t           state_q;
   state_t           state_d;
   logic [CNT_W-1:0] cnt_q;                     // Remaining wait cycles
   logic [CNT_W-1:0] cnt_d;
   slip_t            offset_q;
   logic             pattern_hit;               // Clock word is the training word
   logic             slip;                      // One-cycle step request

   assign pattern_hit = (clk_word_i == CLK_PATTERN);
   assign slip        = (state_q == ST_SLIP);   // High for exactly one cycle per round

   // Next state
   always_comb begin
      state_d = state_q;
      cnt_d   = cnt_q;
      unique case (state_q)
         ST_CHECK: begin
            if (!pattern_hit) begin
               state_d = ST_SLIP;               // Lost or not yet found
            end
         end
         ST_SLIP: begin
            state_d = ST_SETTLE;
         end
         ST_SETTLE: begin
            if (SLIP_WAIT > 1) begin
               state_d = ST_WAIT;
               cnt_d   = CNT_W'(SLIP_WAIT - 2); // Settle already used one cycle
            end else begin
               state_d = ST_CHECK;              // Short wait, test right away
            end
         end
         ST_WAIT: begin
            if (cnt_q == '0) begin
               state_d = ST_CHECK;
            end else begin
               cnt_d = cnt_q - 1'b1;
            end
         end
         default: begin
            state_d = ST_CHECK;
         end
      endcase
   end

   // State, counter and offset registers
   always_ff @(posedge txclk_div) begin
      if (!rst) begin
         state_q  <= ST_CHECK;
         cnt_q    <= '0;
         offset_q <= '0;                        // Start from the unslipped window
      end else begin
         state_q <= state_d;
         cnt_q   <= cnt_d;
         if (slip) begin
            offset_q <= slip_t'(offset_q + 1'b1);   // Wraps 7 to 0
         end
      end
   end

   assign slip_offset_o = offset_q;

   // Lock is the check state seeing the pattern, nothing stored
   // A single bad word drops it and the next round starts
   assign locked_o = (state_q == ST_CHECK) && pattern_hit;

endmodule

//--- src/emmc_serdes_top.sv
`timescale 1ns/100ps

// Word-level core of the source-synchronous eMMC link
// Transmit: eMMC signals packed into a data lane word, clock lane carries
// the training pattern. Receive: both captured lanes go through matching
// gearboxes driven by one offset, so the data lane follows the clock lane.

module emmc_serdes_top
   import emmc_link_pkg::*;
#(
   parameter int LANE_W    = emmc_link_pkg::LANE_W,  // Lane word width
   parameter int SLIP_WAIT = SLIP_WAIT_DEF           // Aligner wait after a slip
)(
   input  logic              txclk_div,        // Word clock
   input  logic              rst,              // Synchronous, active low

   // Transmit side, from the host controller
   input  logic              cmd_i,
   input  logic              cmd_oe_i,
   input  logic              dat_oe_i,
   input  logic [DAT_W-1:0]  dat_i,

   // Captured lane words from the deserializers
   input  logic [LANE_W-1:0] rx_clk_word_i,
   input  logic [LANE_W-1:0] rx_dat_word_i,

   // Lane words to the serializers
   output logic [LANE_W-1:0] tx_clk_word_o,
   output emmc_frame_t       tx_dat_word_o,

   // Receive side, back to the host controller
   output logic              rx_cmd_o,
   output logic              rx_cmd_oe_o,
   output logic              rx_dat_oe_o,
   output logic [DAT_W-1:0]  rx_dat_o,

   // Alignment status
   output logic              locked_o,
   output slip_t             slip_offset_o
);

   logic [LANE_W-1:0] rx_clk_aligned;          // Clock lane after bitslip
   emmc_frame_t       rx_frame;                // Data lane after bitslip
   slip_t             slip_offset;             // Shared by both gearboxes

   emmc_frame_packer u_packer (
      .txclk_div     (txclk_div),
      .rst           (rst),
      .cmd_i         (cmd_i),
      .cmd_oe_i      (cmd_oe_i),
      .dat_oe_i      (dat_oe_i),
      .dat_i         (dat_i),
      .tx_dat_word_o (tx_dat_word_o),
      .tx_clk_word_o (tx_clk_word_o)
   );

   // Clock lane, feeds the aligner
   emmc_lane_gearbox #(.WORD_W(LANE_W)) u_clk_gearbox (
      .txclk_div     (txclk_div),
      .rst           (rst),
      .word_i        (rx_clk_word_i),
      .slip_offset_i (slip_offset),
      .word_o        (rx_clk_aligned)
   );

   // Data lane, slips in step with the clock lane
   emmc_lane_gearbox #(.WORD_W(LANE_W)) u_dat_gearbox (
      .txclk_div     (txclk_div),
      .rst           (rst),
      .word_i        (rx_dat_word_i),
      .slip_offset_i (slip_offset),
      .word_o        (rx_frame)
   );

   emmc_bitslip_aligner #(.SLIP_WAIT(SLIP_WAIT)) u_aligner (
      .txclk_div     (txclk_div),
      .rst           (rst),
      .clk_word_i    (rx_clk_aligned),
      .slip_offset_o (slip_offset),
      .locked_o      (locked_o)
   );

   // Unpack the aligned frame, spare slot is dropped
   assign rx_cmd_o      = rx_frame.cmd;
   assign rx_cmd_oe_o   = rx_frame.cmd_oe;
   assign rx_dat_oe_o   = rx_frame.dat_oe;
   assign rx_dat_o      = rx_frame.dat;
   assign slip_offset_o = slip_offset;

endmodule

//--- dv/tb_clkgen.sv
`timescale 1ns/100ps

// Word clock and reset source for the testbench
module tb_clkgen (
   output logic txclk_div_o,              // 20 ns period
   output logic rst_o                     // Active low, 16 cycles
);

   initial begin
      txclk_div_o = 1'b0;
      forever #10 txclk_div_o = ~txclk_div_o;
   end

   initial begin
      rst_o = 1'b0;
      repeat (16) @(posedge txclk_div_o);
      #2 rst_o = 1'b1;                    // Released just after an edge
   end

endmodule

//--- dv/tb_monitor.sv
`timescale 1ns/100ps

// Watches the DUT and compares against frames it saw driven
module tb_monitor
   import emmc_link_pkg::*;
(
   input  logic        txclk_div,
   input  logic        rst,
   input  logic        cmd_i,
   input  logic        cmd_oe_i,
   input  logic        dat_oe_i,
   input  logic [3:0]  dat_i,
   input  logic [7:0]  tx_clk_word_i,
   input  emmc_frame_t tx_dat_word_i,
   input  logic        rx_cmd_i,
   input  logic        rx_cmd_oe_i,
   input  logic        rx_dat_oe_i,
   input  logic [3:0]  rx_dat_i,
   input  logic        locked_i,
   input  slip_t       slip_offset_i,
   input  logic        check_en_i,         // Frame checks active
   input  logic        lock_wait_i,        // Testbench is waiting for lock
   input  slip_t       exp_slip_i,         // Offset expected for this row
   input  int          lock_bound_i,       // Cycles allowed for lock
   output int          err_cnt_o
);

   emmc_frame_t sampled;                   // Inputs as seen at the edge
   emmc_frame_t hist0, hist1, hist2;       // Frames sampled 0, 1, 2 edges back
   logic        rst_q;                     // Reset level at the last edge
   int          rst_edges;
   int          wait_cnt;
   bit          timeout_noted;
   int          err_cnt;

   assign err_cnt_o = err_cnt;

   // Frame rebuilt in lane bit order with spare at 0
   always_comb begin
      sampled        = '0;
      sampled.cmd    = cmd_i;
      sampled.cmd_oe = cmd_oe_i;
      sampled.dat_oe = dat_oe_i;
      sampled.dat    = dat_i;
   end

   initial begin
      err_cnt       = 0;
      rst_edges     = 0;
      wait_cnt      = 0;
      timeout_noted = 1'b0;
   end

   always @(posedge txclk_div) begin
      hist2 <= hist1;
      hist1 <= hist0;
      hist0 <= sampled;
      rst_q <= rst;
      if (!rst) rst_edges <= rst_edges + 1;
   end

   task automatic flag_mismatch(input string what, input int got, input int exp);
      $display("Error at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
      err_cnt++;
   endtask

   // Compare mid-cycle where every output is settled
   always @(negedge txclk_div) begin
      if (!rst && rst_edges >= 1) begin
         if (locked_i !== 1'b0) flag_mismatch("locked in reset", locked_i, 0);
         if (slip_offset_i !== 3'd0) flag_mismatch("slip in reset", slip_offset_i, 0);
         if ({rx_cmd_i, rx_cmd_oe_i, rx_dat_oe_i, rx_dat_i} !== 7'h7f)
            flag_mismatch("rx outputs in reset",
                          {rx_cmd_i, rx_cmd_oe_i, rx_dat_oe_i, rx_dat_i}, 7'h7f);
         if (tx_dat_word_i !== 8'hfe) flag_mismatch("idle frame", tx_dat_word_i, 8'hfe);
      end
      if (rst_edges >= 1 && tx_clk_word_i !== 8'hc3)
         flag_mismatch("tx_clk_word", tx_clk_word_i, 8'hc3);
      if (rst_q && tx_dat_word_i !== hist0)
         flag_mismatch("tx_dat_word", tx_dat_word_i, hist0);
      if (check_en_i) begin
         if (!locked_i) begin
            $display("Lock dropped at %0t while frames were being checked", $time);
            err_cnt++;
         end
         if (slip_offset_i !== exp_slip_i) flag_mismatch("slip", slip_offset_i, exp_slip_i);
         if (rx_cmd_i !== hist2.cmd) flag_mismatch("rx_cmd", rx_cmd_i, hist2.cmd);
         if (rx_cmd_oe_i !== hist2.cmd_oe) flag_mismatch("rx_cmd_oe", rx_cmd_oe_i, hist2.cmd_oe);
         if (rx_dat_oe_i !== hist2.dat_oe) flag_mismatch("rx_dat_oe", rx_dat_oe_i, hist2.dat_oe);
         if (rx_dat_i !== hist2.dat) flag_mismatch("rx_dat", rx_dat_i, hist2.dat);
      end
      if (lock_wait_i && locked_i && slip_offset_i !== exp_slip_i)
         flag_mismatch("slip at lock", slip_offset_i, exp_slip_i);
      // Lock deadline is reported once per wait
      if (lock_wait_i && !locked_i) begin
         wait_cnt++;
         if (wait_cnt > lock_bound_i && !timeout_noted) begin
            $display("Lock did not arrive within %0d cycles, at %0t", lock_bound_i, $time);
            err_cnt++;
            timeout_noted = 1'b1;
         end
      end else if (!lock_wait_i) begin
         wait_cnt      = 0;
         timeout_noted = 1'b0;
      end
   end

endmodule

//--- dv/emmc_serdes_chk.sv
`timescale 1ns/100ps

// Aligner rules bound into every emmc_bitslip_aligner
module emmc_serdes_chk
   import emmc_link_pkg::*;
(
   input logic        txclk_div,
   input logic        rst,
   input logic [7:0]  clk_word_i,
   input slip_t       slip_offset_i,
   input logic        locked_i
);

   // Offset only ever steps forward by one bit
   a_slip_step: assert property (@(posedge txclk_div) disable iff (!rst)
      1'b1 |=> (slip_offset_i == $past(slip_offset_i)) ||
               (slip_offset_i == slip_t'($past(slip_offset_i) + 3'd1)))
      else $error("slip offset jumped");

   // Offset held while locked
   a_slip_hold: assert property (@(posedge txclk_div) disable iff (!rst)
      locked_i |=> $stable(slip_offset_i))
      else $error("slip offset moved while locked");

   // Lock means the clock lane shows the pattern
   a_lock_pattern: assert property (@(posedge txclk_div) disable iff (!rst)
      locked_i |-> (clk_word_i == CLK_PATTERN))
      else $error("locked without the clock pattern");

endmodule

bind emmc_bitslip_aligner emmc_serdes_chk chk_i (
   .txclk_div     (txclk_div),
   .rst           (rst),
   .clk_word_i    (clk_word_i),
   .slip_offset_i (slip_offset_o),
   .locked_i      (locked_o)
);

//--- dv/tb_top.sv
`timescale 1ns/100ps

// Testbench top with a serial loopback that delays the lanes by a bit count per table row
module tb_top
   import emmc_link_pkg::*;
();

   localparam int N_ROWS    = 5;
   localparam int SLIP_WAIT = 3;
   localparam int LOCK_MAX  = 8 * (SLIP_WAIT + 2) + 4;     // Lock bound from the aligner rule

   // Each row gives bit delay, frame count and expected offset
   localparam int ROW_DELAY[N_ROWS]  = '{3, 0, 5, 7, 2};
   localparam int ROW_FRAMES[N_ROWS] = '{40, 32, 48, 40, 36};
   localparam int ROW_SLIP[N_ROWS]   = '{3, 0, 5, 7, 2};

   logic        txclk_div, rst;
   logic        cmd, cmd_oe, dat_oe;
   logic [3:0]  dat;
   logic [7:0]  rx_clk_word, rx_dat_word;
   logic [7:0]  tx_clk_word;
   emmc_frame_t tx_dat_word;
   logic        rx_cmd, rx_cmd_oe, rx_dat_oe, locked;
   logic [3:0]  rx_dat;
   slip_t       slip_offset, exp_slip;
   logic        loop_en, check_en, lock_wait;
   int          delay_s;
   logic [7:0]  prev_clk, prev_dat;                       // Tx words of the last cycle
   int          err_cnt, cyc_cnt, cycle_limit, wait_cnt;

   tb_clkgen clkgen_i (.txclk_div_o(txclk_div), .rst_o(rst));

   emmc_serdes_top #(.LANE_W(8), .SLIP_WAIT(SLIP_WAIT)) dut_i (
      .txclk_div(txclk_div), .rst(rst), .cmd_i(cmd), .cmd_oe_i(cmd_oe),
      .dat_oe_i(dat_oe), .dat_i(dat), .rx_clk_word_i(rx_clk_word),
      .rx_dat_word_i(rx_dat_word), .tx_clk_word_o(tx_clk_word),
      .tx_dat_word_o(tx_dat_word), .rx_cmd_o(rx_cmd), .rx_cmd_oe_o(rx_cmd_oe),
      .rx_dat_oe_o(rx_dat_oe), .rx_dat_o(rx_dat), .locked_o(locked),
      .slip_offset_o(slip_offset)
   );

   tb_monitor mon_i (
      .txclk_div(txclk_div), .rst(rst), .cmd_i(cmd), .cmd_oe_i(cmd_oe),
      .dat_oe_i(dat_oe), .dat_i(dat), .tx_clk_word_i(tx_clk_word),
      .tx_dat_word_i(tx_dat_word), .rx_cmd_i(rx_cmd), .rx_cmd_oe_i(rx_cmd_oe),
      .rx_dat_oe_i(rx_dat_oe), .rx_dat_i(rx_dat), .locked_i(locked),
      .slip_offset_i(slip_offset), .check_en_i(check_en), .lock_wait_i(lock_wait),
      .exp_slip_i(exp_slip), .lock_bound_i(LOCK_MAX), .err_cnt_o(err_cnt)
   );

   // Wire delay of s bits puts the tail of the last word in front, bit 7 first
   function automatic logic [7:0] delay_bits(input logic [7:0] prev, input logic [7:0] cur,
                                             input int s);
      logic [15:0] pair;
      pair = {prev, cur} >> s;
      return pair[7:0];
   endfunction

   always @(posedge txclk_div) begin
      prev_clk <= tx_clk_word;
      prev_dat <= tx_dat_word;
   end

   always_comb begin
      rx_clk_word = loop_en ? delay_bits(prev_clk, tx_clk_word, delay_s) : 8'hff;
      rx_dat_word = loop_en ? delay_bits(prev_dat, tx_dat_word, delay_s) : 8'hff;
   end

   // One cycle with fresh random inputs driven just after the edge
   task automatic next_cycle();
      @(posedge txclk_div);
      #2;
      {cmd, cmd_oe, dat_oe, dat} = 7'($urandom);
   endtask

   // Run limit
   always @(posedge txclk_div) begin
      cyc_cnt <= cyc_cnt + 1;
      if (cyc_cnt > cycle_limit) begin
         $display("Timeout: run passed %0d cycles without finishing", cycle_limit);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   initial begin
      void'($urandom(32'hcfc5));
      cycle_limit = 16 + 20;
      for (int r = 0; r < N_ROWS; r++) cycle_limit += LOCK_MAX + ROW_FRAMES[r] + 10;
      cyc_cnt   = 0;
      {cmd, cmd_oe, dat_oe, dat} = 7'h7f;                 // Idle bus
      loop_en   = 1'b0;
      check_en  = 1'b0;
      lock_wait = 1'b0;
      exp_slip  = '0;
      delay_s   = 0;
      @(posedge rst);
      next_cycle();
      loop_en = 1'b1;
      for (int r = 0; r < N_ROWS; r++) begin
         delay_s  = ROW_DELAY[r];
         exp_slip = slip_t'(ROW_SLIP[r]);
         // New delay must break the old lock first
         wait_cnt = 0;
         while (r > 0 && locked && wait_cnt < 4) begin
            next_cycle();
            wait_cnt++;
         end
         lock_wait = 1'b1;
         wait_cnt  = 0;
         while (!locked && wait_cnt <= LOCK_MAX + 1) begin
            next_cycle();
            wait_cnt++;
         end
         next_cycle();                                    // First locked cycle shows the offset
         lock_wait = 1'b0;
         repeat (2) next_cycle();                         // History refills at the new offset
         check_en = 1'b1;
         repeat (ROW_FRAMES[r]) next_cycle();
         check_en = 1'b0;
      end
      repeat (2) next_cycle();
      $display("Checks done, %0d errors", err_cnt);
      if (err_cnt == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

//--- emmc_serdes.f
src/emmc_link_pkg.sv
src/emmc_frame_packer.sv
src/emmc_lane_gearbox.sv
src/emmc_bitslip_aligner.sv
src/emmc_serdes_top.sv
dv/tb_clkgen.sv
dv/tb_monitor.sv
dv/emmc_serdes_chk.sv
dv/tb_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the eMMC SerDes testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
   -f emmc_serdes.f -o tb_top_sim > build.log 2>&1 \
   || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_top_sim > sim.log 2>&1
cat sim.log

grep -q "Simulation finished: FAIL" sim.log && exit 1
grep -q "Simulation finished: PASS" sim.log && exit 0 || exit 1
